// ==== hw/bmu_pkg.sv ====
// Shared types for the bit-manipulation unit. RV32 only.
// The operator enum order has no meaning to the encoding.

package bmu_pkg;

  //////////////////////////////
  // Configuration
  //////////////////////////////

  // Enabled B-extension subset
  typedef enum logic [1:0] {
    NONE,              // No B support, everything decodes illegal
    ZBA_ZBB_ZBS,       // Zba, Zbb and Zbs
    ZBA_ZBB_ZBC_ZBS    // Full set including carry-less multiply
  } b_ext_e;

  // Major opcodes
  localparam logic [6:0] OPCODE_OP    = 7'h33;
  localparam logic [6:0] OPCODE_OPIMM = 7'h13;

  //////////////////////////////
  // Operators
  //////////////////////////////

  typedef enum logic [4:0] {
    BMU_SH1ADD, BMU_SH2ADD, BMU_SH3ADD,                  // Zba
    BMU_MIN, BMU_MINU, BMU_MAX, BMU_MAXU,                // Zbb compare
    BMU_ANDN, BMU_ORN, BMU_XNOR,                         // Zbb logic with inversion
    BMU_ROL, BMU_ROR,                                    // Zbb rotates
    BMU_ZEXT_H,
    BMU_CLZ, BMU_CTZ, BMU_CPOP,                          // Zbb counts
    BMU_ORC_B, BMU_REV8,
    BMU_SEXT_B, BMU_SEXT_H,
    BMU_CLMUL, BMU_CLMULH, BMU_CLMULR,                   // Zbc
    BMU_BSET, BMU_BCLR, BMU_BINV, BMU_BEXT               // Zbs
  } bmu_op_e;

  //////////////////////////////
  // Decoder and stage payloads
  //////////////////////////////

  // Decoder output, 7 bits
  typedef struct packed {
    bmu_op_e op;
    logic    imm_sel;  // Operand b from the shamt field
    logic    illegal;
  } bmu_ctrl_t;

  // Illegal until a match says otherwise
  localparam bmu_ctrl_t BMU_CTRL_ILLEGAL = '{
    op:      BMU_SH1ADD,
    imm_sel: 1'b0,
    illegal: 1'b1
  };

  // Stage 1 payload, 76 bits
  typedef struct packed {
    bmu_ctrl_t   ctrl;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [4:0]  imm;  // instr[24:20]
  } bmu_issue_t;

  // Stage 2 payload, 33 bits
  typedef struct packed {
    logic [31:0] result;
    logic        illegal;
  } bmu_result_t;

endpackage

// ==== hw/bmu_decoder.sv ====
// Decodes RV32 Zba/Zbb/Zbc/Zbs encodings only
// Base RV32I encodings and any disabled subset come out illegal
`timescale 1ns/100ps

module bmu_decoder import bmu_pkg::*; #(
  parameter b_ext_e B_EXT = NONE
) (
  input  logic [31:0] instr_i,
  output bmu_ctrl_t   ctrl_o
);

  // Subset enables
  localparam bit ZBA_EN = (B_EXT == ZBA_ZBB_ZBS) || (B_EXT == ZBA_ZBB_ZBC_ZBS);
  localparam bit ZBB_EN = (B_EXT == ZBA_ZBB_ZBS) || (B_EXT == ZBA_ZBB_ZBC_ZBS);
  localparam bit ZBS_EN = (B_EXT == ZBA_ZBB_ZBS) || (B_EXT == ZBA_ZBB_ZBC_ZBS);
  localparam bit ZBC_EN = (B_EXT == ZBA_ZBB_ZBC_ZBS);

  logic [6:0] opcode;
  logic [6:0] funct7;
  logic [4:0] rs2_fld;
  logic [2:0] funct3;

  assign opcode  = instr_i[6:0];
  assign funct7  = instr_i[31:25];
  assign rs2_fld = instr_i[24:20];  // Also shamt or unary sub-op
  assign funct3  = instr_i[14:12];

  // Build a legal control word when the owning subset is on
  function automatic bmu_ctrl_t match(input bmu_op_e op, input logic en, input logic imm);
    bmu_ctrl_t c;
    c = BMU_CTRL_ILLEGAL;
    if (en) begin
      c.op      = op;
      c.imm_sel = imm;
      c.illegal = 1'b0;
    end
    return c;
  endfunction

  always_comb begin
    ctrl_o = BMU_CTRL_ILLEGAL;  // Default until matched

    unique case (opcode)

      //////////////////////////////
      // Register forms
      //////////////////////////////
      OPCODE_OP: begin
        unique case ({funct7, funct3})
          {7'b0010000, 3'b010}: ctrl_o = match(BMU_SH1ADD, ZBA_EN, 1'b0);
          {7'b0010000, 3'b100}: ctrl_o = match(BMU_SH2ADD, ZBA_EN, 1'b0);
          {7'b0010000, 3'b110}: ctrl_o = match(BMU_SH3ADD, ZBA_EN, 1'b0);

          {7'b0000101, 3'b100}: ctrl_o = match(BMU_MIN,  ZBB_EN, 1'b0);
          {7'b0000101, 3'b101}: ctrl_o = match(BMU_MINU, ZBB_EN, 1'b0);
          {7'b0000101, 3'b110}: ctrl_o = match(BMU_MAX,  ZBB_EN, 1'b0);
          {7'b0000101, 3'b111}: ctrl_o = match(BMU_MAXU, ZBB_EN, 1'b0);

          {7'b0100000, 3'b111}: ctrl_o = match(BMU_ANDN, ZBB_EN, 1'b0);
          {7'b0100000, 3'b110}: ctrl_o = match(BMU_ORN,  ZBB_EN, 1'b0);
          {7'b0100000, 3'b100}: ctrl_o = match(BMU_XNOR, ZBB_EN, 1'b0);
          {7'b0110000, 3'b001}: ctrl_o = match(BMU_ROL,  ZBB_EN, 1'b0);
          {7'b0110000, 3'b101}: ctrl_o = match(BMU_ROR,  ZBB_EN, 1'b0);

          // zext.h has rs2 hardwired to x0
          {7'b0000100, 3'b100}: begin
            ctrl_o = match(BMU_ZEXT_H, ZBB_EN && (rs2_fld == 5'b00000), 1'b0);
          end

          {7'b0000101, 3'b001}: ctrl_o = match(BMU_CLMUL,  ZBC_EN, 1'b0);
          {7'b0000101, 3'b011}: ctrl_o = match(BMU_CLMULH, ZBC_EN, 1'b0);
          {7'b0000101, 3'b010}: ctrl_o = match(BMU_CLMULR, ZBC_EN, 1'b0);

          {7'b0010100, 3'b001}: ctrl_o = match(BMU_BSET, ZBS_EN, 1'b0);
          {7'b0100100, 3'b001}: ctrl_o = match(BMU_BCLR, ZBS_EN, 1'b0);
          {7'b0110100, 3'b001}: ctrl_o = match(BMU_BINV, ZBS_EN, 1'b0);
          {7'b0100100, 3'b101}: ctrl_o = match(BMU_BEXT, ZBS_EN, 1'b0);

          default: ctrl_o = BMU_CTRL_ILLEGAL;  // Unknown funct7/funct3
        endcase
      end

      //////////////////////////////
      // Immediate forms
      //////////////////////////////
      OPCODE_OPIMM: begin
        unique casez ({funct7, rs2_fld, funct3})
          // Unary ops pick the operation through the rs2 field
          {7'b0110000, 5'b00000, 3'b001}: ctrl_o = match(BMU_CLZ,    ZBB_EN, 1'b0);
          {7'b0110000, 5'b00001, 3'b001}: ctrl_o = match(BMU_CTZ,    ZBB_EN, 1'b0);
          {7'b0110000, 5'b00010, 3'b001}: ctrl_o = match(BMU_CPOP,   ZBB_EN, 1'b0);
          {7'b0110000, 5'b00100, 3'b001}: ctrl_o = match(BMU_SEXT_B, ZBB_EN, 1'b0);
          {7'b0110000, 5'b00101, 3'b001}: ctrl_o = match(BMU_SEXT_H, ZBB_EN, 1'b0);
          {7'b0010100, 5'b00111, 3'b101}: ctrl_o = match(BMU_ORC_B,  ZBB_EN, 1'b0);
          {7'b0110100, 5'b11000, 3'b101}: ctrl_o = match(BMU_REV8,   ZBB_EN, 1'b0);

          // Shamt forms, bit 25 must be zero on RV32
          {7'b0110000, 5'b?????, 3'b101}: ctrl_o = match(BMU_ROR,  ZBB_EN, 1'b1); // rori
          {7'b0010100, 5'b?????, 3'b001}: ctrl_o = match(BMU_BSET, ZBS_EN, 1'b1); // bseti
          {7'b0100100, 5'b?????, 3'b001}: ctrl_o = match(BMU_BCLR, ZBS_EN, 1'b1); // bclri
          {7'b0110100, 5'b?????, 3'b001}: ctrl_o = match(BMU_BINV, ZBS_EN, 1'b1); // binvi
          {7'b0100100, 5'b?????, 3'b101}: ctrl_o = match(BMU_BEXT, ZBS_EN, 1'b1); // bexti

          default: ctrl_o = BMU_CTRL_ILLEGAL;
        endcase
      end

      default: ctrl_o = BMU_CTRL_ILLEGAL;  // Foreign opcode

    endcase
  end

endmodule

// ==== hw/bmu_clmul.sv ====
// Single-cycle 32x32 carry-less multiply, purely combinational
// Deep XOR tree, so it sets the critical path of the ALU stage
`timescale 1ns/100ps

module bmu_clmul (
  input  logic [31:0] a_i,
  input  logic [31:0] b_i,
  output logic [31:0] clmul_o,   // Low word
  output logic [31:0] clmulh_o,  // High word
  output logic [31:0] clmulr_o   // Reversed, bits 62..31
);

  logic [62:0] prod;  // Bit 63 of the full product is always zero

  // XOR of a shifted copy of a for every set bit of b
  always_comb begin
    prod = '0;
    for (int i = 0; i < 32; i++) begin
      if (b_i[i]) begin
        prod = prod ^ ({31'b0, a_i} << i);
      end
    end
  end

  assign clmul_o  = prod[31:0];
  assign clmulh_o = {1'b0, prod[62:32]};  // Top bit always clear
  assign clmulr_o = prod[62:31];

endmodule

// ==== hw/bmu_alu.sv ====
// Bit-manipulation datapath, no clock
// Result is forced to zero for illegal items
`timescale 1ns/100ps

module bmu_alu import bmu_pkg::*; (
  input  bmu_issue_t  issue_i,
  output logic [31:0] result_o
);

  logic [31:0] rs1;
  logic [31:0] op_b;
  logic [4:0]  sh;         // Shift / bit index
  logic [63:0] rot_l;
  logic [63:0] rot_r;
  logic [5:0]  clz_cnt;
  logic [5:0]  ctz_cnt;
  logic [5:0]  cpop_cnt;
  logic [31:0] orc;
  logic [31:0] rev;
  logic [31:0] clmul;
  logic [31:0] clmulh;
  logic [31:0] clmulr;
  logic [31:0] res;

  assign rs1  = issue_i.rs1;
  assign op_b = issue_i.ctrl.imm_sel ? {27'b0, issue_i.imm} : issue_i.rs2;  // Imm or rs2
  assign sh   = op_b[4:0];

  // Rotates from a doubled operand
  assign rot_l = {rs1, rs1} << sh;   // rol result in upper half
  assign rot_r = {rs1, rs1} >> sh;   // ror result in lower half

  //////////////////////////////
  // Counts
  //////////////////////////////
  always_comb begin
    clz_cnt  = 6'd32;
    ctz_cnt  = 6'd32;
    cpop_cnt = '0;
    for (int i = 0; i < 32; i++) begin
      if (rs1[i]) clz_cnt = 6'(31 - i);       // Last hit is the top set bit
      if (rs1[31 - i]) ctz_cnt = 6'(31 - i);  // Last hit is the bottom set bit
      cpop_cnt = cpop_cnt + 6'(rs1[i]);
    end
  end

  // Byte-wise OR-combine and byte reverse
  always_comb begin
    for (int b = 0; b < 4; b++) begin
      orc[8*b +: 8] = {8{|rs1[8*b +: 8]}};
      rev[8*b +: 8] = rs1[8*(3-b) +: 8];
    end
  end

  bmu_clmul u_clmul (
    .a_i      (rs1),
    .b_i      (op_b),
    .clmul_o  (clmul),
    .clmulh_o (clmulh),
    .clmulr_o (clmulr)
  );

  //////////////////////////////
  // Result select
  //////////////////////////////
  always_comb begin
    case (issue_i.ctrl.op)
      BMU_SH1ADD: res = (rs1 << 1) + op_b;
      BMU_SH2ADD: res = (rs1 << 2) + op_b;
      BMU_SH3ADD: res = (rs1 << 3) + op_b;
      BMU_MIN:    res = ($signed(rs1) < $signed(op_b)) ? rs1 : op_b;
      BMU_MINU:   res = (rs1 < op_b) ? rs1 : op_b;
      BMU_MAX:    res = ($signed(rs1) < $signed(op_b)) ? op_b : rs1;
      BMU_MAXU:   res = (rs1 < op_b) ? op_b : rs1;
      BMU_ANDN:   res = rs1 & ~op_b;
      BMU_ORN:    res = rs1 | ~op_b;
      BMU_XNOR:   res = ~(rs1 ^ op_b);
      BMU_ROL:    res = rot_l[63:32];
      BMU_ROR:    res = rot_r[31:0];
      BMU_ZEXT_H: res = {16'b0, rs1[15:0]};
      BMU_CLZ:    res = {26'b0, clz_cnt};
      BMU_CTZ:    res = {26'b0, ctz_cnt};
      BMU_CPOP:   res = {26'b0, cpop_cnt};
      BMU_ORC_B:  res = orc;
      BMU_REV8:   res = rev;
      BMU_SEXT_B: res = {{24{rs1[7]}}, rs1[7:0]};
      BMU_SEXT_H: res = {{16{rs1[15]}}, rs1[15:0]};
      BMU_CLMUL:  res = clmul;
      BMU_CLMULH: res = clmulh;
      BMU_CLMULR: res = clmulr;
      BMU_BSET:   res = rs1 | (32'b1 << sh);
      BMU_BCLR:   res = rs1 & ~(32'b1 << sh);
      BMU_BINV:   res = rs1 ^ (32'b1 << sh);
      BMU_BEXT:   res = {31'b0, rs1[sh]};
      default:    res = '0;
    endcase
  end

  assign result_o = issue_i.ctrl.illegal ? '0 : res;  // Illegal items carry zero

endmodule

// ==== hw/bmu_pipe_reg.sv ====
// Single-entry valid/ready slice, full rate when downstream is ready
// ready_o depends combinationally on ready_i
`timescale 1ns/100ps

module bmu_pipe_reg #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  assign ready_o = !valid_q || ready_i;  // Empty or draining this cycle

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;  // Load, or empty out on drain with no new item
    end
  end

  // Payload only moves on an upstream transfer
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) data_q <= data_i;
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

// ==== hw/bmu_top.sv ====
// Two-stage B-extension execute unit, latency 2 and one item per cycle
// No forwarding or register file, operands arrive with the instruction
`timescale 1ns/100ps

module bmu_top import bmu_pkg::*; #(
  parameter b_ext_e B_EXT = ZBA_ZBB_ZBC_ZBS
) (
  input  logic        clk_i,
  input  logic        rst_n_i,

  // Issue stream
  input  logic        in_valid_i,
  output logic        in_ready_o,
  input  logic [31:0] in_instr_i,
  input  logic [31:0] in_rs1_i,
  input  logic [31:0] in_rs2_i,

  // Result stream
  output logic        out_valid_o,
  input  logic        out_ready_i,
  output logic [31:0] out_result_o,
  output logic        out_illegal_o
);

  bmu_ctrl_t   dec_ctrl;
  logic        issue_valid;
  logic        issue_ready;   // Result slice ready back to issue slice
  bmu_issue_t  issue_q;
  logic [31:0] alu_result;
  bmu_result_t result_q;

  //////////////////////////////
  // Decode and issue stage
  //////////////////////////////
  bmu_decoder #(
    .B_EXT (B_EXT)
  ) u_decoder (
    .instr_i (in_instr_i),
    .ctrl_o  (dec_ctrl)
  );

  bmu_pipe_reg #(
    .payload_t (bmu_issue_t)
  ) u_issue_reg (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (in_valid_i),
    .ready_o (in_ready_o),
    .data_i  (bmu_issue_t'{ctrl: dec_ctrl, rs1: in_rs1_i, rs2: in_rs2_i,
                           imm: in_instr_i[24:20]}),
    .valid_o (issue_valid),
    .ready_i (issue_ready),
    .data_o  (issue_q)
  );

  //////////////////////////////
  // Execute and result stage
  //////////////////////////////
  bmu_alu u_alu (
    .issue_i  (issue_q),
    .result_o (alu_result)
  );

  bmu_pipe_reg #(
    .payload_t (bmu_result_t)
  ) u_result_reg (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (issue_valid),
    .ready_o (issue_ready),
    .data_i  (bmu_result_t'{result: alu_result, illegal: issue_q.ctrl.illegal}),
    .valid_o (out_valid_o),
    .ready_i (out_ready_i),
    .data_o  (result_q)
  );

  assign out_result_o  = result_q.result;
  assign out_illegal_o = result_q.illegal;

endmodule

// ==== verification/tb_bmu.sv ====
// Vector file path is relative to the project root
// Pass 1 checks latency at full rate and pass 2 adds random gaps and stalls
`timescale 1ns/100ps

module tb_bmu import bmu_pkg::*; ();

  logic        clk_i;
  logic        rst_n_i;
  logic        in_valid_i;
  logic        in_ready_o;
  logic [31:0] in_instr_i;
  logic [31:0] in_rs1_i;
  logic [31:0] in_rs2_i;
  logic        out_valid_o;
  logic        out_ready_i;
  logic [31:0] out_result_o;
  logic        out_illegal_o;

  // Vectors as read from the file
  logic [31:0] vec_instr[$];
  logic [31:0] vec_rs1[$];
  logic [31:0] vec_rs2[$];
  logic [31:0] vec_res[$];
  logic        vec_ill[$];

  // Accepted items still in flight with the oldest first
  logic [31:0] exp_res_q[$];
  logic        exp_ill_q[$];
  int          acc_cyc_q[$];   // Cycle of the input handshake

  int vec_cnt     = 0;
  int cycle_cnt   = 0;
  int cycle_limit = 0;
  int errors      = 0;
  int checks      = 0;
  bit loaded      = 1'b0;

  bmu_top #(
    .B_EXT (ZBA_ZBB_ZBC_ZBS)
  ) UUT (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .in_valid_i    (in_valid_i),
    .in_ready_o    (in_ready_o),
    .in_instr_i    (in_instr_i),
    .in_rs1_i      (in_rs1_i),
    .in_rs2_i      (in_rs2_i),
    .out_valid_o   (out_valid_o),
    .out_ready_i   (out_ready_i),
    .out_result_o  (out_result_o),
    .out_illegal_o (out_illegal_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;  // 20 ns period
  end

  // Watchdog with a limit that scales with the vector count
  initial begin
    wait (loaded);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, not all results came out", cycle_cnt);
    $display("Test failures found");
    $finish;
  end

  //////////////////////////////
  // Tasks
  //////////////////////////////
  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f_instr;
    logic [31:0] f_rs1;
    logic [31:0] f_rs2;
    logic [31:0] f_res;
    logic [31:0] f_ill;
    fd = $fopen("verification/bmu_input_vectors.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the vector file");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        // Comment and blank lines do not scan as five fields
        if (n > 0 && $sscanf(line, "%h %h %h %h %h",
                             f_instr, f_rs1, f_rs2, f_res, f_ill) == 5) begin
          vec_instr.push_back(f_instr);
          vec_rs1.push_back(f_rs1);
          vec_rs2.push_back(f_rs2);
          vec_res.push_back(f_res);
          vec_ill.push_back(f_ill[0]);
        end
      end
      $fclose(fd);
    end
    vec_cnt = vec_instr.size();
  endtask

  // Compare one output transfer with the oldest accepted item
  task automatic check_output(input bit rand_mode);
    logic [31:0] exp_res;
    logic        exp_ill;
    int          acc_cyc;
    checks++;
    if (exp_res_q.size() == 0) begin
      $display("Output at %0t with no item outstanding", $time);
      errors++;
    end else begin
      exp_res = exp_res_q.pop_front();
      exp_ill = exp_ill_q.pop_front();
      acc_cyc = acc_cyc_q.pop_front();
      if (out_result_o !== exp_res) begin
        $display("** Error at %0t: out_result_o expected %h, got %h",
                 $time, exp_res, out_result_o);
        errors++;
      end
      if (out_illegal_o !== exp_ill) begin
        $display("** Error at %0t: out_illegal_o expected %b, got %b",
                 $time, exp_ill, out_illegal_o);
        errors++;
      end
      if (!rand_mode && (cycle_cnt - acc_cyc != 2)) begin
        $display("Result at %0t came %0d cycles after its input instead of 2",
                 $time, cycle_cnt - acc_cyc);
        errors++;
      end
    end
  endtask

  // One pass over all vectors that starts and ends on a rising edge
  task automatic run_pass(input bit rand_mode);
    int sent;
    int got;
    bit busy;  // A vector waits on the input until taken
    sent = 0;
    got  = 0;
    busy = 1'b0;
    while (got < vec_cnt) begin
      if (!busy && sent < vec_cnt && (!rand_mode || $urandom_range(3) != 0)) begin
        busy = 1'b1;
        in_valid_i <= 1'b1;
        in_instr_i <= vec_instr[sent];
        in_rs1_i   <= vec_rs1[sent];
        in_rs2_i   <= vec_rs2[sent];
      end else if (!busy) begin
        in_valid_i <= 1'b0;  // Gap
      end
      out_ready_i <= rand_mode ? ($urandom_range(9) < 7) : 1'b1;  // About 70% ready
      @(negedge clk_i);
      // Both handshakes complete on the next rising edge
      if (out_valid_o && out_ready_i) begin
        check_output(rand_mode);
        got++;
      end
      if (busy && in_ready_o) begin
        exp_res_q.push_back(vec_res[sent]);
        exp_ill_q.push_back(vec_ill[sent]);
        acc_cyc_q.push_back(cycle_cnt);
        sent++;
        busy = 1'b0;
      end
      if (!rand_mode && in_ready_o !== 1'b1) begin
        $display("** Error at %0t: in_ready_o expected 1, got %b", $time, in_ready_o);
        errors++;
      end
      @(posedge clk_i);
    end
    in_valid_i  <= 1'b0;
    out_ready_i <= 1'b1;
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    void'($urandom(43));
    rst_n_i     <= 1'b0;
    in_valid_i  <= 1'b0;
    in_instr_i  <= '0;
    in_rs1_i    <= '0;
    in_rs2_i    <= '0;
    out_ready_i <= 1'b1;
    load_vectors();
    cycle_limit = 10 * vec_cnt + 100;
    loaded = 1'b1;
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    if (out_valid_o !== 1'b0) begin
      $display("** Error at %0t: out_valid_o expected 0, got %b", $time, out_valid_o);
      errors++;
    end
    if (in_ready_o !== 1'b1) begin
      $display("** Error at %0t: in_ready_o expected 1, got %b", $time, in_ready_o);
      errors++;
    end
    if (vec_cnt == 0) begin
      $display("No vectors found in the vector file");
      errors++;
    end else begin
      @(posedge clk_i);
      run_pass(1'b0);
      run_pass(1'b1);
      // Nothing may come out after the last expected item
      repeat (3) begin
        @(negedge clk_i);
        if (out_valid_o !== 1'b0) begin
          $display("** Error at %0t: out_valid_o expected 0, got %b", $time, out_valid_o);
          errors++;
        end
      end
    end
    $display("Checked %0d results, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== verification/bmu_input_vectors.txt ====
// instr rs1 rs2 expected_result expected_illegal, all hex, one vector per line
2020A1B3 00000010 00000003 00000023 0
2020C1B3 80000001 00000005 00000009 0
2020E1B3 12345678 FFFFFFFF 91A2B3BF 0
282091B3 00000000 0000001F 80000000 0
482091B3 FFFFFFFF 0000001F 7FFFFFFF 0
682091B3 A5A5A5A5 00000000 A5A5A5A4 0
4820D1B3 80000000 0000001F 00000001 0
29F09193 00000001 DEADBEEF 80000001 0
49F09193 FFFFFFFF 00000000 7FFFFFFF 0
68509193 00000020 00000000 00000000 0
49F0D193 80000000 00000000 00000001 0
0A20C1B3 80000000 7FFFFFFF 80000000 0
0A20D1B3 80000000 7FFFFFFF 7FFFFFFF 0
0A20E1B3 FFFFFFFF 00000000 00000000 0
0A20F1B3 FFFFFFFF 00000000 FFFFFFFF 0
4020F1B3 FF00FF00 0F0F0F0F F000F000 0
4020E1B3 00000000 0000FFFF FFFF0000 0
4020C1B3 12345678 12345678 FFFFFFFF 0
602091B3 00000003 0000001F 80000001 0
6020D1B3 12345678 00000000 12345678 0
6000D193 CAFEBABE 00000000 CAFEBABE 0
61F0D193 80000000 00000000 00000001 0
60009193 00000000 00000000 00000020 0
60009193 FFFFFFFF 00000000 00000000 0
60109193 00000000 00000000 00000020 0
60109193 FFFFFFFF 00000000 00000000 0
60209193 00000000 00000000 00000000 0
60209193 FFFFFFFF 00000000 00000020 0
2870D193 00120300 00000000 00FFFF00 0
6980D193 12345678 00000000 78563412 0
60409193 00000080 00000000 FFFFFF80 0
60509193 00008000 00000000 FFFF8000 0
0800C1B3 FFFF8001 00000000 00008001 0
0A2091B3 00000003 00000003 00000005 0
0A20B1B3 FFFFFFFF FFFFFFFF 55555555 0
0A20A1B3 FFFFFFFF FFFFFFFF AAAAAAAA 0
FE2091B3 00000001 00000002 00000000 1
0820C1B3 0000FFFF 00000000 00000000 1
123450B7 00000001 00000002 00000000 1

// ==== src.f ====
hw/bmu_pkg.sv
hw/bmu_decoder.sv
hw/bmu_clmul.sv
hw/bmu_alu.sv
hw/bmu_pipe_reg.sv
hw/bmu_top.sv
verification/tb_bmu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -sv --top-module tb_bmu -Mdir obj_dir -o sim_bmu \
  -f src.f > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/sim_bmu > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "Simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q 'All tests passed!' sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL, see sim.log"
  exit 1
fi
